//--- all.f
+incdir+design
design/gpu_pkg.sv
design/sram_pkg.sv
design/ff_cntrlr_intf.sv
design/ff_ptr_cntrlr.sv
design/ff_mem_access.sv
design/ff_sram.sv
design/gpu_ff_top.sv
test/gpu_ff_sva.sv
test/gpu_ff_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the pixel FIFO testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module gpu_ff_tb \
  -f all.f -o gpu_ff_sim > build.log 2>&1 \
  && ./obj_dir/gpu_ff_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- test/gpu_ff_tb.sv
/* Pixel FIFO testbench with clock and reset, queue model, compare tasks
   and directed tests on gpu_ff_top */

`default_nettype none

`include "gpu_defs.svh"

module gpu_ff_tb
  import gpu_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  // Words per region row and the rd_valid wait limit in cycles
  localparam int ROW_WORDS     = `GPU_CANVAS_W / `GPU_WORD_PXLS;
  localparam int VALID_TIMEOUT = 10;

  logic      cr_intf;
  logic      rst_n;
  logic      wr_en;
  pxl_word_t wr_data;
  logic      rd_en;
  pxl_word_t rd_data;
  logic      rd_valid;
  logic      full;
  logic      empty;
  occ_t      occ;
  point_t    wptr;
  point_t    rptr;

  // Reference FIFO contents and access totals
  pxl_word_t model_q[$];
  int        wr_total;
  int        rd_total;
  int        err_count;
  int        errs_before;
  int        test_count;
  int        fail_count;

  gpu_ff_top dut
  (
    .cr_intf  (cr_intf),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .full     (full),
    .empty    (empty),
    .occ      (occ),
    .wptr     (wptr),
    .rptr     (rptr)
  );

  // 8 ns clock
  always
  begin
    #4 cr_intf = ~cr_intf;
  end

  // Step to just after the next rising edge
  task automatic tick();
    @(posedge cr_intf);
    #1;
  endtask

  task automatic check_word(input string name, input pxl_word_t got, input pxl_word_t want);
    if (got !== want)
    begin
      $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, want);
      err_count++;
    end
  endtask

  task automatic check_point(input string name, input point_t got, input point_t want);
    if (got !== want)
    begin
      $display("MISMATCH t=%0t %s got=(x %0d, y %0d) exp=(x %0d, y %0d)",
               $time, name, got.x, got.y, want.x, want.y);
      err_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want)
    begin
      $display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, want);
      err_count++;
    end
  endtask

  task automatic check_occ(input string name, input occ_t got, input occ_t want);
    if (got !== want)
    begin
      $display("MISMATCH t=%0t %s got=%0d exp=%0d", $time, name, got, want);
      err_count++;
    end
  endtask

  // Region point of the n-th word counted row by row from the first row
  function automatic point_t point_of(input int count);
    int     w;
    point_t p;
    w   = count % `FF_DEPTH_WORDS;
    p.x = coord_x_t'((w % ROW_WORDS) * `GPU_WORD_PXLS);
    p.y = coord_y_t'(`FF_START_Y + w / ROW_WORDS);
    return p;
  endfunction

  // Flags, occupancy and pointers against the model
  task automatic verify_state();
    check_flag("full", full, model_q.size() == `FF_DEPTH_WORDS);
    check_flag("empty", empty, model_q.size() == 0);
    check_occ("occ", occ, occ_t'(model_q.size() * `GPU_WORD_PXLS));
    check_point("wptr", wptr, point_of(wr_total));
    check_point("rptr", rptr, point_of(rd_total));
  endtask

  task automatic wait_valid(output int cycles);
    cycles = 0;
    while (rd_valid !== 1'b1 && cycles < VALID_TIMEOUT)
    begin
      tick();
      cycles++;
    end
    if (rd_valid !== 1'b1)
    begin
      $display("ERROR t=%0t rd_valid never rose within %0d cycles", $time, VALID_TIMEOUT);
      err_count++;
    end
  endtask

  // Called right after the accepting edge
  task automatic collect_read(input pxl_word_t want);
    int cycles;
    wait_valid(cycles);
    if (rd_valid === 1'b1 && cycles != 1)
    begin
      $display("ERROR t=%0t rd_valid came %0d cycles after the read, not 1", $time, cycles);
      err_count++;
    end
    check_word("rd_data", rd_data, want);
  endtask

  // After a dropped read rd_valid stays low
  task automatic expect_no_valid();
    repeat (3)
    begin
      tick();
      check_flag("rd_valid", rd_valid, 1'b0);
    end
  endtask

  task automatic drive_write(input pxl_word_t w);
    wr_en   = 1'b1;
    wr_data = w;
    tick();
    wr_en   = 1'b0;
    // Dropped while full
    if (model_q.size() < `FF_DEPTH_WORDS)
    begin
      model_q.push_back(w);
      wr_total++;
    end
    verify_state();
  endtask

  task automatic drive_read();
    pxl_word_t want;
    logic      accepted;
    accepted = (model_q.size() > 0);
    want     = '0;
    rd_en    = 1'b1;
    tick();
    rd_en    = 1'b0;
    if (accepted)
    begin
      want = model_q.pop_front();
      rd_total++;
    end
    verify_state();
    if (accepted)
      collect_read(want);
    else
      expect_no_valid();
  endtask

  task automatic finish_test(input string name);
    test_count++;
    if (err_count != errs_before)
    begin
      fail_count++;
      $display("test %s: failed with %0d errors", name, err_count - errs_before);
    end
    else
      $display("test %s: ok", name);
    errs_before = err_count;
  endtask

  task automatic reset_values();
    verify_state();
    check_flag("rd_valid", rd_valid, 1'b0);
    finish_test("reset_state");
  endtask

  // Eight words fill the region and the ninth is dropped
  task automatic fill_region();
    repeat (`FF_DEPTH_WORDS)
      drive_write(pxl_word_t'($urandom()));
    drive_write(pxl_word_t'($urandom()));
    check_flag("rd_valid", rd_valid, 1'b0);
    finish_test("fill");
  endtask

  task automatic drain_in_order();
    repeat (`FF_DEPTH_WORDS)
      drive_read();
    // Read on empty
    drive_read();
    finish_test("drain");
  endtask

  // Depth held between 1 and 7 words while the pointers lap the region
  task automatic wrap_passes();
    logic do_write;
    for (int i = 0; i < 40; i++)
    begin
      if (model_q.size() <= 1)
        do_write = 1'b1;
      else if (model_q.size() >= `FF_DEPTH_WORDS - 1)
        do_write = 1'b0;
      else
        do_write = (($urandom() % 2) == 0);
      if (do_write)
        drive_write(pxl_word_t'($urandom()));
      else
        drive_read();
    end
    finish_test("wrap");
  endtask

  task automatic read_write_together();
    pxl_word_t w;
    pxl_word_t want;
    occ_t      occ_want;
    while (model_q.size() < 3)
      drive_write(pxl_word_t'($urandom()));
    // One word in and one out keeps the pixel count
    occ_want = occ_t'(model_q.size() * `GPU_WORD_PXLS);
    w       = pxl_word_t'($urandom());
    wr_en   = 1'b1;
    wr_data = w;
    rd_en   = 1'b1;
    tick();
    wr_en   = 1'b0;
    rd_en   = 1'b0;
    want    = model_q.pop_front();
    model_q.push_back(w);
    wr_total++;
    rd_total++;
    check_occ("occ", occ, occ_want);
    verify_state();
    collect_read(want);
    // Drain the rest including the word written with the read
    while (model_q.size() > 0)
      drive_read();
    finish_test("simultaneous");
  endtask

  initial
  begin
    void'($urandom(20854));
    cr_intf     = 1'b0;
    rst_n       = 1'b0;
    wr_en       = 1'b0;
    wr_data     = '0;
    rd_en       = 1'b0;
    wr_total    = 0;
    rd_total    = 0;
    err_count   = 0;
    errs_before = 0;
    test_count  = 0;
    fail_count  = 0;
    repeat (8) @(posedge cr_intf);
    #1;
    rst_n = 1'b1;
    tick();
    reset_values();
    fill_region();
    drain_in_order();
    wrap_passes();
    read_write_together();
    $display("tests run %0d, failed %0d, errors %0d", test_count, fail_count, err_count);
    if (err_count == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/gpu_ff_sva.sv
/* Concurrent checks on the FIFO pointer controller, bound into ff_ptr_cntrlr */

`default_nettype none

`include "gpu_defs.svh"

module gpu_ff_sva
  import gpu_pkg::*;
(
  input logic   cr_intf,
  input logic   rst_n,
  input logic   full,
  input logic   empty,
  input occ_t   occ,
  input point_t wptr
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam coord_y_t START_Y = coord_y_t'(`FF_START_Y);
  localparam coord_y_t END_Y   = coord_y_t'(`FF_END_Y);

  // Flags are exclusive
  flags_excl: assert property (@(posedge cr_intf) disable iff (!rst_n) !(full && empty))
    else $error("full and empty high together");

  // Empty FIFO holds no pixels
  empty_occ: assert property (@(posedge cr_intf) disable iff (!rst_n) empty |-> (occ == '0))
    else $error("occ nonzero while empty");

  // Write point sits on a word boundary
  wptr_align: assert property (@(posedge cr_intf) disable iff (!rst_n) wptr.x[1:0] == 2'b00)
    else $error("wptr.x not a multiple of 4");

  // Write point stays in the region rows
  wptr_rows: assert property (@(posedge cr_intf) disable iff (!rst_n)
                              (wptr.y >= START_Y) && (wptr.y <= END_Y))
    else $error("wptr.y outside the FIFO region");

endmodule

bind ff_ptr_cntrlr gpu_ff_sva u_sva
(
  .cr_intf (cr_intf),
  .rst_n   (rst_n),
  .full    (full_r),
  .empty   (empty_r),
  .occ     (occ_r),
  .wptr    (wptr_r)
);

`default_nettype wire

//--- design/gpu_ff_top.sv
/* GPU pixel FIFO top: pointer controller, memory access and SRAM */

`default_nettype none

`include "gpu_defs.svh"

module gpu_ff_top
  import gpu_pkg::*;
  import sram_pkg::*;
(
  input  logic      cr_intf,
  input  logic      rst_n,
  input  logic      wr_en,
  input  pxl_word_t wr_data,
  input  logic      rd_en,
  output pxl_word_t rd_data,
  output logic      rd_valid,
  output logic      full,
  output logic      empty,
  output occ_t      occ,
  output point_t    wptr,
  output point_t    rptr
);

  // SRAM port wires
  logic       sram_we;
  sram_addr_u sram_waddr;
  pxl_word_t  sram_wdata;
  logic       sram_re;
  sram_addr_u sram_raddr;
  pxl_word_t  sram_rdata;

  ff_cntrlr_intf ff_intf ();

  ff_ptr_cntrlr u_ptr_cntrlr
  (
    .cr_intf (cr_intf),
    .rst_n   (rst_n),
    .ff_intf (ff_intf.ctrl)
  );

  ff_mem_access u_mem_access
  (
    .cr_intf    (cr_intf),
    .rst_n      (rst_n),
    .wr_en      (wr_en),
    .wr_data    (wr_data),
    .rd_en      (rd_en),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid),
    .ff_intf    (ff_intf.mem),
    .sram_we    (sram_we),
    .sram_waddr (sram_waddr),
    .sram_wdata (sram_wdata),
    .sram_re    (sram_re),
    .sram_raddr (sram_raddr),
    .sram_rdata (sram_rdata)
  );

  ff_sram u_sram
  (
    .cr_intf (cr_intf),
    .we      (sram_we),
    .waddr   (sram_waddr),
    .wdata   (sram_wdata),
    .re      (sram_re),
    .raddr   (sram_raddr),
    .rdata   (sram_rdata)
  );

  // FIFO state straight from the controller
  assign full  = ff_intf.full;
  assign empty = ff_intf.empty;
  assign occ   = ff_intf.occ;
  assign wptr  = ff_intf.wptr;
  assign rptr  = ff_intf.rptr;

endmodule

`default_nettype wire

//--- design/ff_sram.sv
/* Simple dual-port synchronous SRAM model, one write and one read port */

`default_nettype none

`include "gpu_defs.svh"

module ff_sram
  import gpu_pkg::*;
  import sram_pkg::*;
(
  input  logic       cr_intf,
  input  logic       we,
  input  sram_addr_u waddr,
  input  pxl_word_t  wdata,
  input  logic       re,
  input  sram_addr_u raddr,
  output pxl_word_t  rdata
);

  // Word array, no reset on contents
  pxl_word_t mem [`SRAM_DEPTH];

  // Write port
  always_ff @(posedge cr_intf)
  begin
    if (we)
      mem[waddr.idx] <= wdata;
  end

  // Read port, data valid one cycle after re
  // Holds last word while re is low
  always_ff @(posedge cr_intf)
  begin
    if (re)
      rdata <= mem[raddr.idx];
  end

endmodule

`default_nettype wire

//--- design/ff_mem_access.sv
/* FIFO memory access: point to SRAM address mapping, SRAM strobes,
   read valid tracking and registered read data */

`default_nettype none

`include "gpu_defs.svh"

module ff_mem_access
  import gpu_pkg::*;
  import sram_pkg::*;
(
  input  logic       cr_intf,
  input  logic       rst_n,
  input  logic       wr_en,
  input  pxl_word_t  wr_data,
  input  logic       rd_en,
  output pxl_word_t  rd_data,
  output logic       rd_valid,
  ff_cntrlr_intf.mem ff_intf,
  output logic       sram_we,
  output sram_addr_u sram_waddr,
  output pxl_word_t  sram_wdata,
  output logic       sram_re,
  output sram_addr_u sram_raddr,
  input  pxl_word_t  sram_rdata
);

  localparam coord_y_t START_Y = coord_y_t'(`FF_START_Y);

  logic      rd_pend;
  pxl_word_t rd_data_r;

  // Region row from y, word column from x / 4
  function automatic sram_addr_u to_addr(input point_t p);
    sram_addr_u a;
    a.pos.row = p.y - START_Y;
    a.pos.col = p.x[`GPU_X_W-1:2];
    return a;
  endfunction

  // Requests pass to the controller for the accept decision
  assign ff_intf.wr_en = wr_en;
  assign ff_intf.rd_en = rd_en;

  // Write lands at the same edge the controller advances wptr
  assign sram_we    = ff_intf.wr_go;
  assign sram_waddr = to_addr(ff_intf.wptr);
  assign sram_wdata = wr_data;

  // SRAM samples the old rptr on the accepting edge
  assign sram_re    = ff_intf.rd_go;
  assign sram_raddr = to_addr(ff_intf.rptr);

  // rd_pend marks a word sitting on the SRAM read port
  always_ff @(posedge cr_intf or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_pend  <= 1'b0;
      rd_valid <= 1'b0;
    end
    else
    begin
      rd_pend  <= ff_intf.rd_go;
      rd_valid <= rd_pend;
    end
  end

  // Hold the word so back-to-back reads do not disturb it
  always_ff @(posedge cr_intf)
  begin
    if (rd_pend)
      rd_data_r <= sram_rdata;
  end

  assign rd_data = rd_data_r;

endmodule

`default_nettype wire

//--- design/ff_ptr_cntrlr.sv
/* Pixel FIFO pointer controller: write and read points, zone bits,
   full / empty flags and pixel occupancy */

`default_nettype none

`include "gpu_defs.svh"

module ff_ptr_cntrlr
  import gpu_pkg::*;
(
  input  logic        cr_intf,
  input  logic        rst_n,
  ff_cntrlr_intf.ctrl ff_intf
);

  // Region bounds as typed constants
  localparam coord_x_t END_X    = coord_x_t'(`FF_END_X);
  localparam coord_x_t X_STEP   = coord_x_t'(`GPU_WORD_PXLS);
  localparam coord_y_t START_Y  = coord_y_t'(`FF_START_Y);
  localparam coord_y_t END_Y    = coord_y_t'(`FF_END_Y);
  localparam occ_t     OCC_STEP = occ_t'(`GPU_WORD_PXLS);

  point_t wptr_r;
  point_t rptr_r;
  logic   wzone_r;
  logic   rzone_r;
  logic   full_r;
  logic   empty_r;
  occ_t   occ_r;

  logic   wr_go;
  logic   rd_go;
  point_t wptr_nxt;
  point_t rptr_nxt;
  logic   wzone_nxt;
  logic   rzone_nxt;
  logic   same_nxt;

  // Last word of the region, the wrap point
  function automatic logic at_end(input point_t p);
    return (p.x == END_X) && (p.y == END_Y);
  endfunction

  // Step one word along the row, then down, then back to the top row
  function automatic point_t adv_ptr(input point_t p, input logic go);
    point_t n;
    n = p;
    if (go)
    begin
      if (p.x == END_X)
      begin
        n.x = '0;
        n.y = (p.y == END_Y) ? START_Y : p.y + 1'b1;
      end
      else
        n.x = p.x + X_STEP;
    end
    return n;
  endfunction

  // Accept only what the current flags allow
  assign wr_go = ff_intf.wr_en & ~full_r;
  assign rd_go = ff_intf.rd_en & ~empty_r;

  assign wptr_nxt  = adv_ptr(wptr_r, wr_go);
  assign rptr_nxt  = adv_ptr(rptr_r, rd_go);

  // Zone flips each time a pointer laps the region
  assign wzone_nxt = wzone_r ^ (wr_go & at_end(wptr_r));
  assign rzone_nxt = rzone_r ^ (rd_go & at_end(rptr_r));

  assign same_nxt  = (wptr_nxt == rptr_nxt);

  always_ff @(posedge cr_intf or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wptr_r  <= '{y: START_Y, x: '0};
      rptr_r  <= '{y: START_Y, x: '0};
      wzone_r <= 1'b0;
      rzone_r <= 1'b0;
    end
    else
    begin
      wptr_r  <= wptr_nxt;
      rptr_r  <= rptr_nxt;
      wzone_r <= wzone_nxt;
      rzone_r <= rzone_nxt;
    end
  end

  // Flags come from next-state pointers, so they track the same edge
  always_ff @(posedge cr_intf or negedge rst_n)
  begin
    if (!rst_n)
    begin
      full_r  <= 1'b0;
      empty_r <= 1'b1;
      occ_r   <= '0;
    end
    else
    begin
      // Equal points: zones differ when full, match when empty
      full_r  <= same_nxt & (wzone_nxt ^ rzone_nxt);
      empty_r <= same_nxt & ~(wzone_nxt ^ rzone_nxt);
      case ({wr_go, rd_go})
        2'b10:   occ_r <= occ_r + OCC_STEP;
        2'b01:   occ_r <= occ_r - OCC_STEP;
        default: occ_r <= occ_r;  // Idle, or one in and one out
      endcase
    end
  end

  assign ff_intf.wr_go = wr_go;
  assign ff_intf.rd_go = rd_go;
  assign ff_intf.full  = full_r;
  assign ff_intf.empty = empty_r;
  assign ff_intf.occ   = occ_r;
  assign ff_intf.wptr  = wptr_r;
  assign ff_intf.rptr  = rptr_r;

endmodule

`default_nettype wire

//--- design/ff_cntrlr_intf.sv
/* Link between pointer controller and memory access block */

`default_nettype none

interface ff_cntrlr_intf
  import gpu_pkg::*;
();

  // Raw requests from the top inputs
  logic   wr_en;
  logic   rd_en;

  // FIFO state
  logic   full;
  logic   empty;
  point_t wptr;
  point_t rptr;
  occ_t   occ;

  // Accepted strobes, decided in the controller only
  logic   wr_go;
  logic   rd_go;

  modport ctrl
  (
    input  wr_en, rd_en,
    output full, empty, wptr, rptr, occ, wr_go, rd_go
  );

  // Memory side needs only the pointers and accept strobes
  modport mem
  (
    output wr_en, rd_en,
    input  wptr, rptr, wr_go, rd_go
  );

endinterface

`default_nettype wire

//--- design/sram_pkg.sv
/* SRAM-side types: region position and the word address union */

`default_nettype none

`include "gpu_defs.svh"

package sram_pkg;

  // Position of a word inside the FIFO region
  // Row is relative to the first region row
  typedef struct packed
  {
    logic [`SRAM_ROW_W-1:0] row;
    logic [`SRAM_COL_W-1:0] col;
  } region_pos_t;

  // One address word, two decodes
  // idx is the flat word index seen by the memory array
  // pos is the row / column view built from a canvas point
  // With col in the low bits, idx equals row * 4 + col
  typedef union packed
  {
    logic [`SRAM_ADDR_W-1:0] idx;
    region_pos_t             pos;
  } sram_addr_u;

endpackage

`default_nettype wire

//--- design/gpu_pkg.sv
/* GPU-side types: coordinates, canvas point, four-pixel word, occupancy */

`default_nettype none

`include "gpu_defs.svh"

package gpu_pkg;

  // Single coordinates, also used for typed constant casts
  typedef logic [`GPU_X_W-1:0] coord_x_t;
  typedef logic [`GPU_Y_W-1:0] coord_y_t;

  // Canvas position, y in the upper bits
  typedef struct packed
  {
    coord_y_t y;
    coord_x_t x;
  } point_t;

  // Four pixels in one SRAM word, pixel 0 in the low byte
  typedef logic [`GPU_WORD_PXLS-1:0][`GPU_PXL_W-1:0] pxl_word_t;

  // FIFO fill level in pixels
  typedef logic [`FF_OCC_W-1:0] occ_t;

endpackage

`default_nettype wire

//--- design/gpu_defs.svh
/* Canvas geometry, pixel packing, FIFO region bounds and SRAM sizing
   for the GPU pixel FIFO */

`ifndef GPU_DEFS_SVH
`define GPU_DEFS_SVH

// Visible canvas in pixels
`define GPU_CANVAS_W    16
`define GPU_CANVAS_H    8

// Width of one point coordinate
`define GPU_X_W         4
`define GPU_Y_W         4

// One SRAM word packs four 8-bit pixels
`define GPU_PXL_W       8
`define GPU_WORD_PXLS   4

// FIFO region starts on the first row below the canvas
`define FF_START_Y      `GPU_CANVAS_H
`define FF_END_Y        (`FF_START_Y + 1)
// Last word column of a region row
`define FF_END_X        (`GPU_CANVAS_W - `GPU_WORD_PXLS)
`define FF_DEPTH_WORDS  8
// Pixel count 0..32 inclusive
`define FF_OCC_W        $clog2(`FF_DEPTH_WORDS * `GPU_WORD_PXLS + 1)

// SRAM word address, split into region row and word column
`define SRAM_ADDR_W     6
`define SRAM_DEPTH      (1 << `SRAM_ADDR_W)
`define SRAM_ROW_W      4
`define SRAM_COL_W      2

`endif
